// File: Bender.yml
package:
  name: exec_cluster

sources:
  - include_dirs:
      - source
    files:
      - source/exec_pkg.sv
      - source/rs_issue_if.sv
      - source/reservation_stations.sv
      - source/issue_unit.sv
      - source/fu_pipelines.sv
      - source/exec_cluster_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/exec_cluster_tb.sv

// File: flist.f
+incdir+source
source/exec_pkg.sv
source/rs_issue_if.sv
source/reservation_stations.sv
source/issue_unit.sv
source/fu_pipelines.sv
source/exec_cluster_top.sv
verification/exec_cluster_tb.sv

// File: source/exec_cluster_top.sv
`include "exec_defines.svh"

module exec_cluster_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  logic [1:0]               dispatch_kind,
    input  logic [`ROB_TAG_LEN-1:0]  dispatch_tag,
    output logic [`FU_KINDS-1:0]     rs_busy,
    output logic [`FU_KINDS-1:0]     issue_signal,
    output logic                     cdb_valid,
    output logic [1:0]               cdb_kind,
    output logic [`ROB_TAG_LEN-1:0]  cdb_tag
);

    exec_pkg::fu_kind_e dispatch_kind_e;
    exec_pkg::fu_kind_e cdb_kind_e;

    assign dispatch_kind_e = exec_pkg::fu_kind_e'(dispatch_kind);
    assign cdb_kind        = cdb_kind_e;

    rs_issue_if rs_if ();

    reservation_stations reservation_stations_inst (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_kind  (dispatch_kind_e),
        .dispatch_tag   (dispatch_tag),
        .rs_busy        (rs_busy),
        .rs             (rs_if.station)
    );

    issue_unit issue_unit_inst (
        .clk          (clk),
        .reset        (reset),
        .rs           (rs_if.issuer),
        .issue_signal (issue_signal)
    );

    fu_pipelines fu_pipelines_inst (
        .clk       (clk),
        .reset     (reset),
        .grant     (rs_if.grant),
        .grant_tag (rs_if.grant_tag),
        .cdb_valid (cdb_valid),
        .cdb_kind  (cdb_kind_e),
        .cdb_tag   (cdb_tag)
    );

endmodule

// File: source/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// reorder-buffer tag width
`define ROB_TAG_LEN 6

// one reservation station and one pipeline per kind
`define FU_KINDS 4

// unit latencies in cycles, grant edge to CDB edge
`define LAT_INT 1
`define LAT_BR  1
`define LAT_LS  4
`define LAT_MUL 8

// CDB reservation window, covers the slowest unit
`define SLOT_DEPTH 8

`endif

// File: source/exec_pkg.sv
`include "exec_defines.svh"

package exec_pkg;

    // functional unit kinds, also the round-robin order
    typedef enum logic [1:0] {
        fu_int    = 2'd0,
        fu_branch = 2'd1,
        fu_ldst   = 2'd2,
        fu_mul    = 2'd3
    } fu_kind_e;

    // fixed pipeline latency per kind
    function automatic int fu_latency(fu_kind_e kind);
        int lat;
        case (kind)
            fu_int:    lat = `LAT_INT;
            fu_branch: lat = `LAT_BR;
            fu_ldst:   lat = `LAT_LS;
            fu_mul:    lat = `LAT_MUL;
            default:   lat = `LAT_INT;
        endcase
        return lat;
    endfunction

endpackage

// File: source/fu_pipelines.sv
`include "exec_defines.svh"

module fu_pipelines (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`FU_KINDS-1:0]     grant,
    input  logic [`ROB_TAG_LEN-1:0]  grant_tag,
    output logic                     cdb_valid,
    output exec_pkg::fu_kind_e       cdb_kind,
    output logic [`ROB_TAG_LEN-1:0]  cdb_tag
);

    logic [`FU_KINDS-1:0]                   done;     // last stage valid per kind
    logic [`FU_KINDS-1:0][`ROB_TAG_LEN-1:0] done_tag;
    logic [1:0]                             merge_kind;
    logic [`ROB_TAG_LEN-1:0]                merge_tag;

    // tag shift pipeline per kind, depth = latency
    for (genvar k = 0; k < `FU_KINDS; k++) begin : g_pipe
        localparam int LAT = exec_pkg::fu_latency(exec_pkg::fu_kind_e'(k));

        logic [LAT-1:0]                   stage_vld;
        logic [LAT-1:0][`ROB_TAG_LEN-1:0] stage_tag;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                stage_vld <= '0;
            end else begin
                stage_vld[0] <= grant[k];
                for (int i = 1; i < LAT; i++) begin
                    stage_vld[i] <= stage_vld[i-1];
                end
            end
        end

        // payload just follows the valid bits
        always_ff @(posedge clk) begin
            stage_tag[0] <= grant_tag;
            for (int i = 1; i < LAT; i++) begin
                stage_tag[i] <= stage_tag[i-1];
            end
        end

        assign done[k]     = stage_vld[LAT-1];
        assign done_tag[k] = stage_tag[LAT-1];
    end

    // at most one done bit, so an OR merge is enough
    always_comb begin
        merge_kind = 2'd0;
        merge_tag  = '0;
        for (int k = 0; k < `FU_KINDS; k++) begin
            merge_kind = merge_kind | (2'(k) & {2{done[k]}});
            merge_tag  = merge_tag | (done_tag[k] & {`ROB_TAG_LEN{done[k]}});
        end
    end

    // CDB register, one cycle per result
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= |done;
        end
    end

    always_ff @(posedge clk) begin
        cdb_kind <= exec_pkg::fu_kind_e'(merge_kind);
        cdb_tag  <= merge_tag;
    end

    // slot reservation upstream keeps completions apart
    a_single_completion: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(done)
    ) else $error("CDB collision, done = %b", done);

endmodule

// File: source/issue_unit.sv
`include "exec_defines.svh"

module issue_unit (
    input  logic                 clk,
    input  logic                 reset,
    rs_issue_if.issuer           rs,
    output logic [`FU_KINDS-1:0] issue_signal
);

    // bit i set: CDB taken i+2 cycles after the current cycle starts
    logic [`SLOT_DEPTH-1:0] sched;
    logic [`SLOT_DEPTH-1:0] slot_mask;
    logic [`SLOT_DEPTH-1:0] sched_next;

    exec_pkg::fu_kind_e rr_ptr; // first kind to look at

    logic [`FU_KINDS-1:0] slot_free;
    logic [`FU_KINDS-1:0] elig;
    logic [`FU_KINDS-1:0] pick;
    exec_pkg::fu_kind_e   pick_kind;
    logic                 pick_valid;
    logic [1:0]           cand_idx;

    // result slot for each kind, checked against the schedule
    always_comb begin
        for (int k = 0; k < `FU_KINDS; k++) begin
            slot_free[k] = !sched[exec_pkg::fu_latency(exec_pkg::fu_kind_e'(k)) - 1];
        end
    end

    assign elig = rs.ready & slot_free; // blocked entries retry next cycle

    // rotating priority search starting at rr_ptr
    always_comb begin
        pick       = '0;
        pick_kind  = exec_pkg::fu_int;
        pick_valid = 1'b0;
        cand_idx   = 2'd0;
        for (int off = 0; off < `FU_KINDS; off++) begin
            cand_idx = 2'(rr_ptr + off);
            if (!pick_valid && elig[cand_idx]) begin
                pick_valid     = 1'b1;
                pick_kind      = exec_pkg::fu_kind_e'(cand_idx);
                pick[cand_idx] = 1'b1;
            end
        end
    end

    assign rs.grant     = pick;
    assign rs.grant_tag = rs.tags[pick_kind];

    // slot claimed by this cycle's pick
    always_comb begin
        slot_mask = '0;
        if (pick_valid) begin
            slot_mask[exec_pkg::fu_latency(pick_kind) - 1] = 1'b1;
        end
    end

    // mark, then advance one cycle
    assign sched_next = (sched | slot_mask) >> 1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sched        <= '0;
            rr_ptr       <= exec_pkg::fu_int;
            issue_signal <= '0;
        end else begin
            sched        <= sched_next;
            issue_signal <= pick; // registered grant strobe
            if (pick_valid) begin
                rr_ptr <= exec_pkg::fu_kind_e'(2'(pick_kind + 2'd1)); // kind after the winner
            end
        end
    end

    // a faster kind granted GAP cycles after a slower one would land on its slot
    for (genvar j = 0; j < `FU_KINDS; j++) begin : g_book
        for (genvar k = 0; k < `FU_KINDS; k++) begin : g_later
            localparam int GAP = exec_pkg::fu_latency(exec_pkg::fu_kind_e'(j))
                               - exec_pkg::fu_latency(exec_pkg::fu_kind_e'(k));
            if (GAP > 0) begin : g_chk
                a_no_double_book: assert property (
                    @(posedge clk) disable iff (reset)
                    rs.grant[j] |-> ##GAP !rs.grant[k]
                ) else $error("CDB slot double booked, kind %0d after kind %0d", k, j);
            end
        end
    end

endmodule

// File: source/reservation_stations.sv
`include "exec_defines.svh"

module reservation_stations (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  exec_pkg::fu_kind_e       dispatch_kind,
    input  logic [`ROB_TAG_LEN-1:0]  dispatch_tag,
    output logic [`FU_KINDS-1:0]     rs_busy,
    rs_issue_if.station              rs
);

    logic [`FU_KINDS-1:0]                   entry_valid;
    logic [`FU_KINDS-1:0][`ROB_TAG_LEN-1:0] entry_tag;
    logic [`FU_KINDS-1:0]                   dispatch_hit;

    // decode dispatch target
    always_comb begin
        dispatch_hit = '0;
        if (dispatch_valid) begin
            dispatch_hit[dispatch_kind] = 1'b1;
        end
    end

    // one entry per kind; dispatch sets, grant clears
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            for (int k = 0; k < `FU_KINDS; k++) begin
                if (dispatch_hit[k]) begin
                    entry_valid[k] <= 1'b1;
                end else if (rs.grant[k]) begin
                    entry_valid[k] <= 1'b0; // leaves at the grant edge
                end
            end
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        for (int k = 0; k < `FU_KINDS; k++) begin
            if (dispatch_hit[k]) begin
                entry_tag[k] <= dispatch_tag;
            end
        end
    end

    assign rs.ready = entry_valid;
    assign rs.tags  = entry_tag;
    assign rs_busy  = entry_valid; // busy until granted

    // dispatcher must wait for the station to drain
    a_no_busy_dispatch: assert property (
        @(posedge clk) disable iff (reset)
        dispatch_valid |-> !entry_valid[dispatch_kind]
    ) else $error("dispatch to busy station %s", dispatch_kind.name());

    // issue unit grants at most one entry, and only a live one
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(rs.grant) && ((rs.grant & ~entry_valid) == '0)
    ) else $error("bad grant vector %b", rs.grant);

endmodule

// File: source/rs_issue_if.sv
`include "exec_defines.svh"

// stations report ready entries, issue unit answers with a grant
interface rs_issue_if;

    logic [`FU_KINDS-1:0]                   ready;     // entry valid per kind
    logic [`FU_KINDS-1:0][`ROB_TAG_LEN-1:0] tags;      // entry tag per kind
    logic [`FU_KINDS-1:0]                   grant;     // one-hot pick this cycle
    logic [`ROB_TAG_LEN-1:0]                grant_tag; // tag of the picked entry

    modport station (
        output ready,
        output tags,
        input  grant
    );

    modport issuer (
        input  ready,
        input  tags,
        output grant,
        output grant_tag
    );

endinterface

// File: verification/exec_cluster_tb.sv
`include "exec_defines.svh"

module exec_cluster_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS     = 23;
    localparam int RESET_CYCLES = 5;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    dispatch_valid;
    logic [1:0]              dispatch_kind;
    logic [`ROB_TAG_LEN-1:0] dispatch_tag;
    logic [`FU_KINDS-1:0]    rs_busy;
    logic [`FU_KINDS-1:0]    issue_signal;
    logic                    cdb_valid;
    logic [1:0]              cdb_kind;
    logic [`ROB_TAG_LEN-1:0] cdb_tag;

    // stimulus table, cycles count rising edges from the start
    int tbl_disp  [NUM_ROWS];
    int tbl_kind  [NUM_ROWS];
    int tbl_tag   [NUM_ROWS];
    int tbl_issue [NUM_ROWS];
    int tbl_cdb   [NUM_ROWS];
    int row_count = 0;

    // events seen by the monitor
    int issue_cycle_q [$];
    int issue_kind_q  [$];
    int cdb_cycle_q   [$];
    int cdb_kind_q    [$];
    int cdb_tag_q     [$];

    int     cyc           = 0;
    int     errors        = 0;
    int     timeout_limit = 1000;
    integer seed;

    exec_cluster_top exec_cluster_top_inst (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_kind  (dispatch_kind),
        .dispatch_tag   (dispatch_tag),
        .rs_busy        (rs_busy),
        .issue_signal   (issue_signal),
        .cdb_valid      (cdb_valid),
        .cdb_kind       (cdb_kind),
        .cdb_tag        (cdb_tag)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_limit) begin
            $display("timeout: no complete result stream after %0d cycles", timeout_limit);
            $display("errors: %0d", errors);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic add_row(input int disp, input exec_pkg::fu_kind_e kind, input int tag,
                           input int issue, input int cdb);
        tbl_disp[row_count]  = disp;
        tbl_kind[row_count]  = int'(kind);
        tbl_tag[row_count]   = tag & 'h3f;
        tbl_issue[row_count] = issue;
        tbl_cdb[row_count]   = cdb;
        row_count++;
    endtask

    // kind is busy from its dispatch edge up to its grant edge
    function automatic logic [`FU_KINDS-1:0] expected_busy(input int c);
        logic [`FU_KINDS-1:0] busy;
        busy = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (c >= tbl_disp[r] && c < tbl_issue[r]) begin
                busy[tbl_kind[r]] = 1'b1;
            end
        end
        return busy;
    endfunction

    // index of the n-th recorded issue of one kind, -1 if missing
    function automatic int nth_issue(input int kind, input int n);
        int seen;
        int idx;
        seen = 0;
        idx  = -1;
        for (int i = 0; i < issue_kind_q.size(); i++) begin
            if (issue_kind_q[i] == kind) begin
                if (seen == n && idx < 0) begin
                    idx = i;
                end
                seen++;
            end
        end
        return idx;
    endfunction

    function automatic int nth_cdb(input int kind, input int n);
        int seen;
        int idx;
        seen = 0;
        idx  = -1;
        for (int i = 0; i < cdb_kind_q.size(); i++) begin
            if (cdb_kind_q[i] == kind) begin
                if (seen == n && idx < 0) begin
                    idx = i;
                end
                seen++;
            end
        end
        return idx;
    endfunction

    // outputs only change on rising edges, so sample on falling ones
    always @(negedge clk) begin
        if (cyc <= RESET_CYCLES) begin
            check_value(issue_signal, 0, "issue_signal during reset");
            check_value(cdb_valid, 0, "cdb_valid during reset");
            check_value(rs_busy, 0, "rs_busy during reset");
        end else begin
            check_value(rs_busy, expected_busy(cyc), $sformatf("rs_busy in cycle %0d", cyc));
            for (int k = 0; k < `FU_KINDS; k++) begin
                if (issue_signal[k]) begin
                    issue_cycle_q.push_back(cyc);
                    issue_kind_q.push_back(k);
                end
            end
            if (cdb_valid) begin
                cdb_cycle_q.push_back(cyc);
                cdb_kind_q.push_back(int'(cdb_kind));
                cdb_tag_q.push_back(int'(cdb_tag));
            end
        end
    end

    // per kind, the n-th row matches the n-th issue and the n-th result
    task automatic compare_events();
        int seen [`FU_KINDS];
        int k;
        int idx;
        for (int i = 0; i < `FU_KINDS; i++) begin
            seen[i] = 0;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            k = tbl_kind[r];
            idx = nth_issue(k, seen[k]);
            if (idx < 0) begin
                $display("row %0d was never issued", r);
                errors++;
            end else begin
                check_value(issue_cycle_q[idx], tbl_issue[r], $sformatf("issue cycle row %0d", r));
            end
            idx = nth_cdb(k, seen[k]);
            if (idx < 0) begin
                $display("row %0d never reached the CDB", r);
                errors++;
            end else begin
                check_value(cdb_cycle_q[idx], tbl_cdb[r], $sformatf("CDB cycle row %0d", r));
                check_value(cdb_tag_q[idx], tbl_tag[r], $sformatf("CDB tag row %0d", r));
            end
            seen[k]++;
        end
        check_value(issue_cycle_q.size(), NUM_ROWS, "number of issue pulses");
        check_value(cdb_cycle_q.size(), NUM_ROWS, "number of CDB results");
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_kind  = 2'd0;
        dispatch_tag   = '0;
        seed           = 92873;

        // each kind alone in an idle cluster
        add_row(10, exec_pkg::fu_int,    'h05, 11, 12);
        add_row(14, exec_pkg::fu_branch, 'h0a, 15, 16);
        add_row(18, exec_pkg::fu_ldst,   'h11, 19, 23);
        add_row(26, exec_pkg::fu_mul,    'h22, 27, 35);
        add_row(33, exec_pkg::fu_int,    'h07, 35, 36); // slot 35 held by the mul
        // fillers reserve 48, 49, 50 and 53
        add_row(40, exec_pkg::fu_mul,    'h30, 41, 49);
        add_row(43, exec_pkg::fu_ldst,   'h31, 44, 48);
        add_row(44, exec_pkg::fu_mul,    'h32, 45, 53);
        add_row(45, exec_pkg::fu_ldst,   'h33, 46, 50);
        // all four waiting in the cycle up to edge 50, pointer at mul
        add_row(46, exec_pkg::fu_int,    'h34, 51, 52);
        add_row(47, exec_pkg::fu_branch, 'h35, 53, 54); // skipped at 52, slot 53 taken
        add_row(48, exec_pkg::fu_ldst,   'h36, 52, 56);
        add_row(49, exec_pkg::fu_mul,    'h37, 50, 58);
        // back-to-back ldst and mul, several in flight
        add_row(62, exec_pkg::fu_ldst,   'h18, 63, 67);
        add_row(63, exec_pkg::fu_mul,    'h19, 64, 72);
        add_row(64, exec_pkg::fu_ldst,   'h1a, 65, 69);
        add_row(65, exec_pkg::fu_mul,    'h1b, 66, 74);
        add_row(66, exec_pkg::fu_ldst,   'h1c, 67, 71);
        add_row(67, exec_pkg::fu_mul,    'h1d, 68, 76);
        // random tags, idle stations only
        add_row(80, exec_pkg::fu_branch, $random(seed), 81, 82);
        add_row(84, exec_pkg::fu_mul,    $random(seed), 85, 93);
        add_row(86, exec_pkg::fu_int,    $random(seed), 87, 88);
        add_row(90, exec_pkg::fu_ldst,   $random(seed), 91, 95);

        timeout_limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (tbl_cdb[r] > timeout_limit) begin
                timeout_limit = tbl_cdb[r];
            end
        end
        timeout_limit = timeout_limit + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // drive each row on the falling edge before its dispatch edge
        for (int r = 0; r < NUM_ROWS; r++) begin
            while (cyc < tbl_disp[r] - 1) begin
                @(negedge clk);
                dispatch_valid = 1'b0;
            end
            dispatch_valid = 1'b1;
            dispatch_kind  = 2'(tbl_kind[r]);
            dispatch_tag   = tbl_tag[r][`ROB_TAG_LEN-1:0];
        end
        @(negedge clk);
        dispatch_valid = 1'b0;

        while (cdb_cycle_q.size() < NUM_ROWS) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // catch stray pulses

        compare_events();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
